//--- vpu_settings.svh
`ifndef VPU_SETTINGS_SVH
`define VPU_SETTINGS_SVH

// horizontal timing in pixel clocks
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// vertical timing in lines
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

`define FIFO_DEPTH 16
`define COLOR_BITS 8
`define COORD_BITS 10

`endif

//--- video_pkg.sv
`include "vpu_settings.svh"

package video_pkg;

	typedef logic [`COLOR_BITS-1:0] colour_t;

	typedef logic [`COORD_BITS-1:0] coord_t; // wide enough for the blanking counts too

	typedef struct packed {
		colour_t red;
		colour_t green;
		colour_t blue;
	} rgb_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} scan_pos_t;

	// what the composer draws for one frame
	typedef struct packed {
		rgb_t   background;
		coord_t rect_x;
		coord_t rect_y;
		coord_t rect_w;
		coord_t rect_h;
		rgb_t   rect_colour;
	} scene_cfg_t;

endpackage

//--- host_pkg.sv
package host_pkg;

	typedef enum logic {
		set_background = 1'b0,
		set_rect       = 1'b1
	} cmd_kind_t;

	typedef struct packed {
		video_pkg::coord_t x;
		video_pkg::coord_t y;
		video_pkg::coord_t width;
		video_pkg::coord_t height;
	} rect_t;

	typedef struct packed {
		logic [15:0]     pad;    // unused upper bits
		video_pkg::rgb_t colour;
	} bg_word_t;

	// one 40-bit payload word, meaning picked by the command kind
	typedef union packed {
		rect_t    rect;
		bg_word_t bg;
	} cmd_payload_u;

	typedef struct packed {
		cmd_kind_t       kind;
		cmd_payload_u    payload;
		video_pkg::rgb_t rect_colour;
	} command_t;

	typedef struct packed {
		logic up, down, left, right;
		logic a, b, c, start;
		logic x, y, z, mode;
	} buttons_t;

endpackage

//--- command_port.sv
`timescale 1ns/1ps

module command_port (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  cmd_req,
	input  host_pkg::command_t    cmd,
	output logic                  cmd_ack,
	output video_pkg::scene_cfg_t scene
);
	import host_pkg::*;

	typedef enum logic {
		idle,
		acked
	} state_t;

	state_t state;

	assign cmd_ack = (state == acked);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			scene <= '0;                  // black background, empty rectangle
		end else begin
			case (state)
				idle: if (cmd_req) begin
					state <= acked;
					case (cmd.kind)
						set_background: scene.background <= cmd.payload.bg.colour;
						set_rect: begin
							scene.rect_x      <= cmd.payload.rect.x;
							scene.rect_y      <= cmd.payload.rect.y;
							scene.rect_w      <= cmd.payload.rect.width;
							scene.rect_h      <= cmd.payload.rect.height;
							scene.rect_colour <= cmd.rect_colour;
						end
					endcase
				end
				acked: if (!cmd_req) begin
					state <= idle;            // host released, close handshake
				end
			endcase
		end
	end

endmodule

//--- frame_composer.sv
`timescale 1ns/1ps
`include "vpu_settings.svh"

module frame_composer (
	input  logic                  clk,
	input  logic                  reset,
	input  video_pkg::scene_cfg_t scene,
	input  logic                  full,
	output logic                  push,
	output video_pkg::rgb_t       wdata
);
	import video_pkg::*;

	scan_pos_t            pos;       // pixel being composed
	scene_cfg_t           work;      // settings for the current frame
	logic                 running;
	logic [`COORD_BITS:0] x_end;     // one past the rectangle, may exceed the screen
	logic [`COORD_BITS:0] y_end;
	logic                 inside_x;
	logic                 inside_y;

	assign x_end = {1'b0, work.rect_x} + work.rect_w;
	assign y_end = {1'b0, work.rect_y} + work.rect_h;

	assign inside_x = (pos.x >= work.rect_x) && ({1'b0, pos.x} < x_end);
	assign inside_y = (pos.y >= work.rect_y) && ({1'b0, pos.y} < y_end);

	assign wdata = (inside_x && inside_y) ? work.rect_colour : work.background;
	assign push  = running && !full;  // hold while the FIFO is full

	always_ff @(posedge clk) begin
		if (reset) begin
			pos     <= '0;
			work    <= '0;
			running <= 1'b0;
		end else begin
			running <= 1'b1;
			if (push) begin
				if (pos.x == coord_t'(`H_ACTIVE - 1)) begin
					pos.x <= '0;
					if (pos.y == coord_t'(`V_ACTIVE - 1)) begin
						pos.y <= '0;
						work  <= scene;        // pick up new settings at (0,0) only
					end else begin
						pos.y <= pos.y + 1'b1;
					end
				end else begin
					pos.x <= pos.x + 1'b1;
				end
			end
		end
	end

endmodule

//--- pixel_fifo.sv
`timescale 1ns/1ps
`include "vpu_settings.svh"

module pixel_fifo (
	input  logic            clk,
	input  logic            reset,
	input  logic            push,
	input  video_pkg::rgb_t wdata,
	input  logic            pop,
	output video_pkg::rgb_t rdata,
	output logic            full,
	output logic            empty
);
	import video_pkg::*;

	localparam int ADDR_W = $clog2(`FIFO_DEPTH);
	localparam logic [ADDR_W:0] DEPTH = `FIFO_DEPTH;

	rgb_t              mem [`FIFO_DEPTH];
	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] rd_ptr;
	logic [ADDR_W:0]   count;
	logic              do_push;
	logic              do_pop;

	function automatic logic [ADDR_W-1:0] next_ptr(input logic [ADDR_W-1:0] p);
		return (p == ADDR_W'(`FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full    = (count == DEPTH);
	assign empty   = (count == '0);
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= wdata;
		if (do_pop)
			rdata <= mem[rd_ptr];  // read data valid the cycle after pop
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // idle or both
			endcase
		end
	end

endmodule

//--- scan_timing.sv
`timescale 1ns/1ps
`include "vpu_settings.svh"

module scan_timing (
	input  logic               clk,
	input  logic               reset,
	input  video_pkg::rgb_t    rdata,
	input  logic               empty,
	output logic               pop,
	output video_pkg::coord_t  x,
	output video_pkg::coord_t  y,
	output logic               hs_n,
	output logic               vs_n,
	output logic               blank_n,
	output video_pkg::colour_t red,
	output video_pkg::colour_t green,
	output video_pkg::colour_t blue,
	output logic               frame_start,
	output logic               underrun
);
	import video_pkg::*;

	scan_pos_t pos;          // pixel on the outputs now
	scan_pos_t pos_next;     // pixel fetched this cycle
	logic      pre_request;
	logic      shown;        // FIFO delivered a colour for this pixel

	always_comb begin
		pos_next = pos;
		if (pos.x == coord_t'(`H_TOTAL - 1)) begin
			pos_next.x = '0;
			if (pos.y == coord_t'(`V_TOTAL - 1))
				pos_next.y = '0;
			else
				pos_next.y = pos.y + 1'b1;
		end else begin
			pos_next.x = pos.x + 1'b1;
		end
	end

	assign pre_request = (pos_next.x < `H_ACTIVE) && (pos_next.y < `V_ACTIVE);
	assign pop         = pre_request && !empty;

	always_ff @(posedge clk) begin
		if (reset) begin
			pos.x    <= '0;
			pos.y    <= coord_t'(`V_ACTIVE);  // begin in vertical blank, FIFO fills meanwhile
			shown    <= 1'b0;
			underrun <= 1'b0;
		end else begin
			pos   <= pos_next;
			shown <= pop;
			if (pre_request && empty)
				underrun <= 1'b1;               // sticky
		end
	end

	assign x       = pos.x;
	assign y       = pos.y;
	assign blank_n = (pos.x < `H_ACTIVE) && (pos.y < `V_ACTIVE);
	assign hs_n    = !((pos.x >= `H_ACTIVE + `H_FRONT) &&
		(pos.x < `H_ACTIVE + `H_FRONT + `H_SYNC));
	assign vs_n    = !((pos.y >= `V_ACTIVE + `V_FRONT) &&
		(pos.y < `V_ACTIVE + `V_FRONT + `V_SYNC));

	assign frame_start = (pos.x == '0) && (pos.y == '0);

	// black in blanking and on underrun
	assign red   = (blank_n && shown) ? rdata.red : '0;
	assign green = (blank_n && shown) ? rdata.green : '0;
	assign blue  = (blank_n && shown) ? rdata.blue : '0;

endmodule

//--- gamepad_scanner.sv
`timescale 1ns/1ps

module gamepad_scanner (
	input  logic               clk,
	input  logic               reset,
	input  logic               frame_start,
	input  logic [5:0]         pins,      // {pin9, pin6, pin4, pin3, pin2, pin1}
	output logic               select,
	output host_pkg::buttons_t buttons
);
	import host_pkg::*;

	localparam logic [3:0] LOW_SAMPLE  = 4'd4;
	localparam logic [3:0] HIGH_SAMPLE = 4'd8;
	localparam logic [3:0] LAST_STEP   = 4'd9;

	logic [3:0] step;     // 0 when idle
	logic [5:0] pressed;
	buttons_t   staged;

	assign pressed = ~pins;  // pad pulls pins low when pressed

	always_ff @(posedge clk) begin
		if (reset) begin
			step    <= '0;
			select  <= 1'b1;
			buttons <= '0;
		end else if (step == '0) begin
			if (frame_start) begin
				step   <= 4'd1;
				select <= 1'b0;      // first phase reads a and start
			end
		end else begin
			step <= (step == LAST_STEP) ? '0 : step + 1'b1;
			if (step == LOW_SAMPLE)
				select <= 1'b1;
			if (step == LAST_STEP)
				buttons <= staged;   // lands 10 cycles after frame_start
		end
	end

	always_ff @(posedge clk) begin
		if (step == LOW_SAMPLE) begin
			staged <= '{a: pressed[4], start: pressed[5], default: 1'b0};
		end else if (step == HIGH_SAMPLE) begin
			staged.up    <= pressed[0];
			staged.down  <= pressed[1];
			staged.left  <= pressed[2];
			staged.right <= pressed[3];
			staged.b     <= pressed[4];
			staged.c     <= pressed[5];
		end
	end

endmodule

//--- visual_processing_unit.sv
`timescale 1ns/1ps

module visual_processing_unit (
	input  logic               clk,
	input  logic               reset,
	input  logic               cmd_req,
	input  host_pkg::command_t cmd,
	output logic               cmd_ack,
	input  logic [5:0]         pad_pins,
	output logic               pad_select,
	output host_pkg::buttons_t buttons,
	output video_pkg::coord_t  x,
	output video_pkg::coord_t  y,
	output logic               hs_n,
	output logic               vs_n,
	output logic               blank_n,
	output video_pkg::colour_t red,
	output video_pkg::colour_t green,
	output video_pkg::colour_t blue,
	output logic               underrun
);
	import video_pkg::*;

	scene_cfg_t scene;
	rgb_t       wdata;
	rgb_t       rdata;
	logic       push;
	logic       full;
	logic       pop;
	logic       empty;
	logic       frame_start;

	command_port cmd_port (
		.clk(clk), .reset(reset),
		.cmd_req(cmd_req), .cmd(cmd), .cmd_ack(cmd_ack),
		.scene(scene)
	);

	frame_composer composer (
		.clk(clk), .reset(reset),
		.scene(scene), .full(full), .push(push), .wdata(wdata)
	);

	pixel_fifo fifo (
		.clk(clk), .reset(reset),
		.push(push), .wdata(wdata), .pop(pop), .rdata(rdata),
		.full(full), .empty(empty)
	);

	scan_timing scan (
		.clk(clk), .reset(reset),
		.rdata(rdata), .empty(empty), .pop(pop),
		.x(x), .y(y), .hs_n(hs_n), .vs_n(vs_n), .blank_n(blank_n),
		.red(red), .green(green), .blue(blue),
		.frame_start(frame_start), .underrun(underrun)
	);

	gamepad_scanner pad (
		.clk(clk), .reset(reset),
		.frame_start(frame_start), .pins(pad_pins),
		.select(pad_select), .buttons(buttons)
	);

endmodule

//--- vpu_tb.sv
`timescale 1ns/1ps
`include "vpu_settings.svh"

module vpu_tb;
	import video_pkg::*;
	import host_pkg::*;

	localparam int CYCLE_LIMIT = 3 * `H_TOTAL * `V_TOTAL + 1000;  // three frames plus slack

	logic        clk = 1'b0;
	logic        reset;
	logic        cmd_req;
	command_t    cmd;
	logic        cmd_ack;
	logic [5:0]  pad_pins;
	logic        pad_select;
	buttons_t    buttons;
	coord_t      x;
	coord_t      y;
	logic        hs_n;
	logic        vs_n;
	logic        blank_n;
	colour_t     red;
	colour_t     green;
	colour_t     blue;
	logic        underrun;

	logic [15:0] lfsr;
	buttons_t    pad_set;        // buttons the pad model holds down
	rgb_t        bg_colour;
	rgb_t        rect_colour;
	rgb_t        expect_rgb;
	int          rect_x;
	int          rect_y;
	int          rect_w;
	int          rect_h;
	int          frame_count;    // bumps on the last pixel of each frame
	int          check_frame;
	int          hs_low;
	int          vs_low;
	int          cycles = 0;
	logic        cmds_started;
	logic        frame_top;
	logic        in_rect;

	visual_processing_unit DUT (
		.clk(clk), .reset(reset),
		.cmd_req(cmd_req), .cmd(cmd), .cmd_ack(cmd_ack),
		.pad_pins(pad_pins), .pad_select(pad_select), .buttons(buttons),
		.x(x), .y(y), .hs_n(hs_n), .vs_n(vs_n), .blank_n(blank_n),
		.red(red), .green(green), .blue(blue), .underrun(underrun)
	);

	always #50 clk = ~clk;

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);   // one step per bit
		end
	endtask

	// active-low pin levels of a three-button pad
	function automatic logic [5:0] pad_levels(input logic sel, input buttons_t b);
		if (sel)
			return ~{b.c, b.b, b.right, b.left, b.down, b.up};
		else
			return ~{b.start, b.a, 1'b1, 1'b1, b.down, b.up};  // pins 3 and 4 grounded
	endfunction

	task automatic abort_run;
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic fail_check(input string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
		abort_run();
	endtask

	task automatic send_command(input command_t c);
		@(negedge clk);
		cmd     = c;
		cmd_req = 1'b1;
		do @(negedge clk); while (!cmd_ack);
		cmd_req = 1'b0;
		do @(negedge clk); while (cmd_ack);
	endtask

	always @(negedge clk)
		pad_pins <= pad_levels(pad_select, pad_set);

	always_comb begin
		in_rect = (int'(x) >= rect_x) && (int'(x) < rect_x + rect_w) &&
			(int'(y) >= rect_y) && (int'(y) < rect_y + rect_h);
		expect_rgb = in_rect ? rect_colour : bg_colour;
	end

	assign frame_top = !reset && (x == '0) && (y == '0);

	always @(posedge clk) begin
		if (reset) begin
			hs_low      <= 0;
			vs_low      <= 0;
			frame_count <= 0;
		end else begin
			hs_low <= hs_n ? 0 : hs_low + 1;
			vs_low <= vs_n ? 0 : vs_low + 1;
			if (x == coord_t'(`H_TOTAL - 1) && y == coord_t'(`V_TOTAL - 1))
				frame_count <= frame_count + 1;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
			abort_run();
		end
	end

	ack_rise: assert property (@(posedge clk) disable iff (reset)
		$rose(cmd_ack) |-> $past(cmd_req)) else fail_check("cmd_ack rose without cmd_req");
	ack_fall: assert property (@(posedge clk) disable iff (reset)
		$fell(cmd_ack) |-> !$past(cmd_req)) else fail_check("cmd_ack fell while cmd_req high");
	ack_hold: assert property (@(posedge clk) disable iff (reset)
		cmd_ack && cmd_req |=> cmd_ack) else fail_check("cmd_ack dropped early");
	blank_area: assert property (@(posedge clk) disable iff (reset)
		blank_n == (x < `H_ACTIVE && y < `V_ACTIVE)) else fail_check("blank_n wrong");
	black_start: assert property (@(posedge clk) disable iff (reset)
		blank_n && !cmds_started |-> {red, green, blue} == '0)
		else fail_check("pixel not black before any command");
	no_underrun: assert property (@(posedge clk) disable iff (reset)
		!underrun) else fail_check("FIFO underrun");
	hs_start: assert property (@(posedge clk) disable iff (reset)
		$fell(hs_n) |-> x == `H_ACTIVE + `H_FRONT) else fail_check("hsync starts at wrong x");
	hs_width: assert property (@(posedge clk) disable iff (reset)
		$rose(hs_n) |-> hs_low == `H_SYNC) else fail_check("hsync width wrong");
	vs_start: assert property (@(posedge clk) disable iff (reset)
		$fell(vs_n) |-> y == `V_ACTIVE + `V_FRONT && x == '0)
		else fail_check("vsync starts at wrong line");
	vs_width: assert property (@(posedge clk) disable iff (reset)
		$rose(vs_n) |-> vs_low == `V_SYNC * `H_TOTAL) else fail_check("vsync width wrong");
	render: assert property (@(posedge clk) disable iff (reset)
		blank_n && frame_count == check_frame |-> {red, green, blue} == expect_rgb)
		else fail_check("pixel colour does not match scene");
	pad_phase: assert property (@(posedge clk) disable iff (reset)
		pad_select == !($past(frame_top, 1) || $past(frame_top, 2) ||
			$past(frame_top, 3) || $past(frame_top, 4)))
		else fail_check("pad select low at the wrong time");
	pad_word: assert property (@(posedge clk) disable iff (reset)
		$past(frame_top, 10) |-> buttons == pad_set) else fail_check("button word wrong");
	pad_unused: assert property (@(posedge clk) disable iff (reset)
		!(buttons.x || buttons.y || buttons.z || buttons.mode))
		else fail_check("six-button bits set");

	initial begin
		command_t    c;
		logic [31:0] v;
		reset        = 1'b1;
		cmd_req      = 1'b0;
		cmd          = '0;
		pad_pins     = '1;
		cmds_started = 1'b0;
		check_frame  = -1;
		lfsr         = 16'd16074;
		random_bits(8, v);
		pad_set       = '0;
		pad_set.up    = v[0];
		pad_set.down  = v[1];
		pad_set.left  = v[2];
		pad_set.right = v[3];
		pad_set.a     = v[4];
		pad_set.b     = v[5];
		pad_set.c     = v[6];
		pad_set.start = v[7];
		random_bits(24, v);
		bg_colour = v[23:0];
		random_bits(9, v);
		rect_x = v;
		random_bits(8, v);
		rect_y = v;
		random_bits(8, v);
		rect_w = v + 1;
		random_bits(8, v);
		rect_h = v + 1;
		random_bits(24, v);
		rect_colour = v[23:0];
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		do @(negedge clk); while (!(frame_count == 1 && y == `V_ACTIVE));  // frame 1 stays black
		cmds_started = 1'b1;
		c = '0;
		c.kind = set_background;
		c.payload.bg.colour = bg_colour;
		send_command(c);
		c = '0;
		c.kind = set_rect;
		c.payload.rect.x      = coord_t'(rect_x);
		c.payload.rect.y      = coord_t'(rect_y);
		c.payload.rect.width  = coord_t'(rect_w);
		c.payload.rect.height = coord_t'(rect_h);
		c.rect_colour         = rect_colour;
		send_command(c);
		check_frame = frame_count + 2;  // second full frame after the ack
		do @(negedge clk); while (!(frame_count == check_frame && y == `V_ACTIVE));
		$display("Test completed successfully");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+.
video_pkg.sv
host_pkg.sv
command_port.sv
frame_composer.sv
pixel_fifo.sv
scan_timing.sv
gamepad_scanner.sv
visual_processing_unit.sv
vpu_tb.sv
